//--- design/cache_pkg.sv
// Cache geometry, Wishbone cycle types and burst engine modes
// Address union, line type and controller state type
package cache_pkg;

        // Geometry
        localparam int LINE_BYTES = 16;
        localparam int LINE_WORDS = LINE_BYTES / 4;
        localparam int NUM_LINES  = 16;
        localparam int OFS_W      = $clog2(LINE_WORDS);
        localparam int IDX_W      = $clog2(NUM_LINES);
        localparam int TAG_W      = 32 - IDX_W - OFS_W - 2;

        // Wishbone cycle type indicator
        localparam logic [2:0] CTI_CLASSIC = 3'b000;
        localparam logic [2:0] CTI_BURST   = 3'b010;
        localparam logic [2:0] CTI_EOB     = 3'b111;

        // Burst engine modes
        localparam logic [1:0] MODE_LINE_RD = 2'd0;
        localparam logic [1:0] MODE_LINE_WR = 2'd1;
        localparam logic [1:0] MODE_SINGLE  = 2'd2;

        typedef logic [LINE_WORDS-1:0][31:0] line_t;

        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] index;
                logic [OFS_W-1:0] word;
                logic [1:0]       boff;   // Byte within word
        } addr_fields_t;

        // Same 32 bits, bus view or lookup view
        typedef union packed {
                logic [31:0]  flat;
                addr_fields_t fields;
        } cache_addr_t;

        typedef enum logic [1:0] {
                IDLE,
                UNCACHED,
                WRITEBACK,
                FILL
        } ctrl_state_t;

endpackage

//--- design/cache_store.sv
// Direct-mapped tag, valid, dirty and data arrays
// Combinational lookup, byte-enabled line write
`timescale 1ns/1ps

module cache_store (
        input  logic                             i_clk,
        input  logic                             i_reset,
        input  cache_pkg::cache_addr_t           i_address,
        input  logic                             i_line_we,
        input  cache_pkg::line_t                 i_line,
        input  logic [cache_pkg::LINE_BYTES-1:0] i_line_ben,
        input  logic [cache_pkg::TAG_W-1:0]      i_tag,
        input  logic                             i_dirty,
        output logic                             o_hit,
        output logic                             o_dirty,
        output logic [31:0]                      o_rd_word,
        output cache_pkg::line_t                 o_victim_line,
        output logic [cache_pkg::TAG_W-1:0]      o_victim_tag
);
        import cache_pkg::*;

        logic [NUM_LINES-1:0] valid_q;
        logic [NUM_LINES-1:0] dirty_q;
        logic [TAG_W-1:0]     tag_q  [NUM_LINES];
        line_t                data_q [NUM_LINES];
        logic [IDX_W-1:0]     idx;

        assign idx = i_address.fields.index;

        // --------------------
        // Lookup
        // --------------------
        assign o_hit         = valid_q[idx] && (tag_q[idx] == i_address.fields.tag);
        assign o_dirty       = valid_q[idx] && dirty_q[idx];   // Victim needs writeback
        assign o_rd_word     = data_q[idx][i_address.fields.word];
        assign o_victim_line = data_q[idx];
        assign o_victim_tag  = tag_q[idx];

        // --------------------
        // Update
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        valid_q <= '0;
                        dirty_q <= '0;
                end
                else if (i_line_we)
                begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= i_dirty;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_line_we)
                begin
                        tag_q[idx] <= i_tag;
                        for (int b = 0; b < LINE_BYTES; b++)
                        begin
                                if (i_line_ben[b])
                                        data_q[idx][b/4][8*(b%4) +: 8] <= i_line[b/4][8*(b%4) +: 8];
                        end
                end
        end

endmodule

//--- design/line_burst.sv
// Wishbone master for incrementing line bursts and single classic cycles
`timescale 1ns/1ps

module line_burst (
        input  logic             i_clk,
        input  logic             i_reset,
        input  logic             i_start,
        input  logic [1:0]       i_mode,
        input  logic [31:0]      i_base,
        input  cache_pkg::line_t i_line_out,
        input  logic             i_single_we,
        input  logic [31:0]      i_single_dat,
        input  logic [3:0]       i_single_sel,
        output logic             o_done,
        output cache_pkg::line_t o_line_in,
        output logic [31:0]      o_single_rd,
        output logic             o_wb_cyc,
        output logic             o_wb_stb,
        output logic             o_wb_we,
        output logic [31:0]      o_wb_adr,
        output logic [31:0]      o_wb_dat,
        output logic [3:0]       o_wb_sel,
        output logic [2:0]       o_wb_cti,
        input  logic             i_wb_ack,
        input  logic [31:0]      i_wb_dat
);
        import cache_pkg::*;

        logic [1:0]       mode_q;
        logic [OFS_W-1:0] cnt_q;     // Beat number within the line
        line_t            line_q;    // Collected read beats
        logic             launch;
        logic             beat;
        logic             last;

        assign launch = i_start && !o_wb_cyc;
        assign beat   = o_wb_stb && i_wb_ack;
        assign last   = (mode_q == MODE_SINGLE) || (cnt_q == OFS_W'(LINE_WORDS - 1));

        assign o_line_in   = line_q;
        assign o_single_rd = line_q[0];   // Single read lands in word 0

        // --------------------
        // Bus control
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_wb_cti <= CTI_CLASSIC;
                        o_done   <= 1'b0;
                        mode_q   <= MODE_LINE_RD;
                        cnt_q    <= '0;
                end
                else
                begin
                        o_done <= 1'b0;
                        if (launch)
                        begin
                                o_wb_cyc <= 1'b1;
                                o_wb_stb <= 1'b1;
                                o_wb_we  <= (i_mode == MODE_LINE_WR) ||
                                            ((i_mode == MODE_SINGLE) && i_single_we);
                                o_wb_cti <= (i_mode == MODE_SINGLE) ? CTI_CLASSIC : CTI_BURST;
                                mode_q   <= i_mode;
                                cnt_q    <= '0;
                        end
                        else if (beat)
                        begin
                                if (last)
                                begin
                                        o_wb_cyc <= 1'b0;
                                        o_wb_stb <= 1'b0;
                                        o_wb_we  <= 1'b0;
                                        o_wb_cti <= CTI_CLASSIC;
                                        o_done   <= 1'b1;
                                end
                                else
                                begin
                                        cnt_q <= cnt_q + 1'b1;
                                        if (cnt_q == OFS_W'(LINE_WORDS - 2))
                                                o_wb_cti <= CTI_EOB;   // Next beat ends the line
                                end
                        end
                end
        end

        // --------------------
        // Address and data
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (launch)
                begin
                        o_wb_adr <= i_base;
                        o_wb_dat <= (i_mode == MODE_SINGLE) ? i_single_dat : i_line_out[0];
                        o_wb_sel <= (i_mode == MODE_SINGLE) ? i_single_sel : 4'hf;
                end
                else if (beat)
                begin
                        line_q[cnt_q] <= i_wb_dat;
                        if (!last)
                        begin
                                o_wb_adr <= o_wb_adr + 32'd4;
                                o_wb_dat <= i_line_out[cnt_q + 1'b1];
                        end
                end
        end

endmodule

//--- design/cache_ctrl.sv
// Cache controller FSM: hit, fill, writeback and uncached paths
`timescale 1ns/1ps

module cache_ctrl (
        input  logic                             i_clk,
        input  logic                             i_reset,
        // CPU
        input  logic                             i_rd,
        input  logic                             i_wr,
        input  cache_pkg::cache_addr_t           i_address,
        input  logic [31:0]                      i_din,
        input  logic [3:0]                       i_ben,
        input  logic                             i_cache_en,
        output logic [31:0]                      o_dat,
        output logic                             o_ack,
        output logic                             o_retry,
        // Store
        output cache_pkg::cache_addr_t           o_st_address,
        output logic                             o_st_line_we,
        output cache_pkg::line_t                 o_st_line,
        output logic [cache_pkg::LINE_BYTES-1:0] o_st_line_ben,
        output logic [cache_pkg::TAG_W-1:0]      o_st_tag,
        output logic                             o_st_dirty,
        input  logic                             i_st_hit,
        input  logic                             i_st_dirty,
        input  logic [31:0]                      i_st_rd_word,
        input  cache_pkg::line_t                 i_st_victim_line,
        input  logic [cache_pkg::TAG_W-1:0]      i_st_victim_tag,
        // Burst engine
        output logic                             o_bu_start,
        output logic [1:0]                       o_bu_mode,
        output logic [31:0]                      o_bu_base,
        output cache_pkg::line_t                 o_bu_line_out,
        output logic                             o_bu_single_we,
        output logic [31:0]                      o_bu_single_dat,
        output logic [3:0]                       o_bu_single_sel,
        input  logic                             i_bu_done,
        input  cache_pkg::line_t                 i_bu_line_in,
        input  logic [31:0]                      i_bu_single_rd
);
        import cache_pkg::*;

        ctrl_state_t state_q;
        ctrl_state_t state_nxt;
        cache_addr_t addr_q;
        logic [31:0] din_q;
        logic [3:0]  ben_q;
        logic        wr_q;
        logic        unc_done_q;   // Engine finished the single cycle
        logic        req;
        line_t       merged;

        assign req          = i_rd || i_wr;
        assign o_st_address = (state_q == IDLE) ? i_address : addr_q;
        assign o_dat        = (state_q == UNCACHED) ? i_bu_single_rd : i_st_rd_word;

        assign o_bu_line_out   = i_st_victim_line;   // Stable, index is held out of IDLE
        assign o_bu_single_we  = i_wr;
        assign o_bu_single_dat = i_din;
        assign o_bu_single_sel = i_ben;

        // Fetched line with the pending write bytes laid over it
        always_comb
        begin
                merged = i_bu_line_in;
                for (int b = 0; b < 4; b++)
                begin
                        if (wr_q && ben_q[b])
                                merged[addr_q.fields.word][8*b +: 8] = din_q[8*b +: 8];
                end
        end

        // --------------------
        // Next state
        // --------------------
        always_comb
        begin
                state_nxt     = state_q;
                o_ack         = 1'b0;
                o_retry       = 1'b0;
                o_bu_start    = 1'b0;
                o_bu_mode     = MODE_LINE_RD;
                o_bu_base     = i_address.flat;
                o_st_line_we  = 1'b0;
                o_st_line     = {LINE_WORDS{i_din}};
                o_st_line_ben = LINE_BYTES'(i_ben) << {i_address.fields.word, 2'b00};
                o_st_tag      = i_address.fields.tag;
                o_st_dirty    = 1'b1;

                case (state_q)
                IDLE:
                begin
                        if (req && !i_cache_en)
                        begin
                                o_bu_start = 1'b1;
                                o_bu_mode  = MODE_SINGLE;
                                state_nxt  = UNCACHED;
                        end
                        else if (req && i_st_hit)
                        begin
                                o_ack        = 1'b1;
                                o_st_line_we = i_wr;   // Write hit merges bytes
                        end
                        else if (req)
                        begin
                                o_ack      = 1'b1;
                                o_retry    = 1'b1;
                                o_bu_start = 1'b1;
                                if (i_st_dirty)
                                begin
                                        o_bu_mode = MODE_LINE_WR;
                                        o_bu_base = {i_st_victim_tag, i_address.fields.index,
                                                     {(OFS_W + 2){1'b0}}};
                                        state_nxt = WRITEBACK;
                                end
                                else
                                begin
                                        o_bu_base = {i_address.fields.tag, i_address.fields.index,
                                                     {(OFS_W + 2){1'b0}}};
                                        state_nxt = FILL;
                                end
                        end
                end

                UNCACHED:
                begin
                        if (unc_done_q)
                        begin
                                o_ack     = 1'b1;
                                state_nxt = IDLE;
                        end
                end

                WRITEBACK:
                begin
                        o_ack   = req;
                        o_retry = req;
                        if (i_bu_done)
                        begin
                                // Keep data and tag, drop dirty
                                o_st_line_we  = 1'b1;
                                o_st_line_ben = '0;
                                o_st_tag      = i_st_victim_tag;
                                o_st_dirty    = 1'b0;
                                state_nxt     = IDLE;
                        end
                end

                FILL:
                begin
                        o_ack   = req;
                        o_retry = req;
                        if (i_bu_done)
                        begin
                                o_st_line_we  = 1'b1;
                                o_st_line     = merged;
                                o_st_line_ben = '1;
                                o_st_tag      = addr_q.fields.tag;
                                o_st_dirty    = wr_q;
                                state_nxt     = IDLE;
                        end
                end

                default: state_nxt = IDLE;
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q    <= IDLE;
                        unc_done_q <= 1'b0;
                end
                else
                begin
                        state_q    <= state_nxt;
                        unc_done_q <= (state_q == UNCACHED) && i_bu_done;
                end
        end

        // Request captured while idle, held for the transfer
        always_ff @(posedge i_clk)
        begin
                if (state_q == IDLE)
                begin
                        addr_q <= i_address;
                        din_q  <= i_din;
                        ben_q  <= i_ben;
                        wr_q   <= i_wr;
                end
        end

endmodule

//--- design/cache_top.sv
// Cache top level: store, burst engine and controller
`timescale 1ns/1ps

module cache_top (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_rd,
        input  logic        i_wr,
        input  logic [31:0] i_address,
        input  logic [31:0] i_din,
        input  logic [3:0]  i_ben,
        input  logic        i_cache_en,
        output logic [31:0] o_dat,
        output logic        o_ack,
        output logic        o_retry,
        output logic        o_wb_cyc,
        output logic        o_wb_stb,
        output logic        o_wb_we,
        output logic [31:0] o_wb_adr,
        output logic [31:0] o_wb_dat,
        output logic [3:0]  o_wb_sel,
        output logic [2:0]  o_wb_cti,
        input  logic        i_wb_ack,
        input  logic [31:0] i_wb_dat
);
        import cache_pkg::*;

        // Controller to store
        cache_addr_t           st_address;
        logic                  st_line_we;
        line_t                 st_line;
        logic [LINE_BYTES-1:0] st_line_ben;
        logic [TAG_W-1:0]      st_tag;
        logic                  st_dirty;
        logic                  st_hit;
        logic                  st_victim_dirty;
        logic [31:0]           st_rd_word;
        line_t                 st_victim_line;
        logic [TAG_W-1:0]      st_victim_tag;

        // Controller to burst engine
        logic                  bu_start;
        logic [1:0]            bu_mode;
        logic [31:0]           bu_base;
        line_t                 bu_line_out;
        logic                  bu_single_we;
        logic [31:0]           bu_single_dat;
        logic [3:0]            bu_single_sel;
        logic                  bu_done;
        line_t                 bu_line_in;
        logic [31:0]           bu_single_rd;

        cache_store u_store (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_address     (st_address),
                .i_line_we     (st_line_we),
                .i_line        (st_line),
                .i_line_ben    (st_line_ben),
                .i_tag         (st_tag),
                .i_dirty       (st_dirty),
                .o_hit         (st_hit),
                .o_dirty       (st_victim_dirty),
                .o_rd_word     (st_rd_word),
                .o_victim_line (st_victim_line),
                .o_victim_tag  (st_victim_tag)
        );

        line_burst u_burst (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_start      (bu_start),
                .i_mode       (bu_mode),
                .i_base       (bu_base),
                .i_line_out   (bu_line_out),
                .i_single_we  (bu_single_we),
                .i_single_dat (bu_single_dat),
                .i_single_sel (bu_single_sel),
                .o_done       (bu_done),
                .o_line_in    (bu_line_in),
                .o_single_rd  (bu_single_rd),
                .o_wb_cyc     (o_wb_cyc),
                .o_wb_stb     (o_wb_stb),
                .o_wb_we      (o_wb_we),
                .o_wb_adr     (o_wb_adr),
                .o_wb_dat     (o_wb_dat),
                .o_wb_sel     (o_wb_sel),
                .o_wb_cti     (o_wb_cti),
                .i_wb_ack     (i_wb_ack),
                .i_wb_dat     (i_wb_dat)
        );

        cache_ctrl u_ctrl (
                .i_clk            (i_clk),
                .i_reset          (i_reset),
                .i_rd             (i_rd),
                .i_wr             (i_wr),
                .i_address        (i_address),
                .i_din            (i_din),
                .i_ben            (i_ben),
                .i_cache_en       (i_cache_en),
                .o_dat            (o_dat),
                .o_ack            (o_ack),
                .o_retry          (o_retry),
                .o_st_address     (st_address),
                .o_st_line_we     (st_line_we),
                .o_st_line        (st_line),
                .o_st_line_ben    (st_line_ben),
                .o_st_tag         (st_tag),
                .o_st_dirty       (st_dirty),
                .i_st_hit         (st_hit),
                .i_st_dirty       (st_victim_dirty),
                .i_st_rd_word     (st_rd_word),
                .i_st_victim_line (st_victim_line),
                .i_st_victim_tag  (st_victim_tag),
                .o_bu_start       (bu_start),
                .o_bu_mode        (bu_mode),
                .o_bu_base        (bu_base),
                .o_bu_line_out    (bu_line_out),
                .o_bu_single_we   (bu_single_we),
                .o_bu_single_dat  (bu_single_dat),
                .o_bu_single_sel  (bu_single_sel),
                .i_bu_done        (bu_done),
                .i_bu_line_in     (bu_line_in),
                .i_bu_single_rd   (bu_single_rd)
        );

endmodule

//--- test/cache_properties.sv
// Wishbone master assertions for the line burst engine, bound into line_burst
`timescale 1ns/1ps

module cache_properties (
        input logic                        i_clk,
        input logic                        i_reset,
        input logic                        i_cyc,
        input logic                        i_stb,
        input logic                        i_ack,
        input logic [31:0]                 i_adr,
        input logic [2:0]                  i_cti,
        input logic [cache_pkg::OFS_W-1:0] i_beat
);
        import cache_pkg::*;

        a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
                i_stb |-> i_cyc)
                else $error("stb raised outside a bus cycle");

        a_reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> (!i_cyc && !i_stb))
                else $error("bus cycle active right after reset");

        // Waiting beat keeps its address and cycle type
        a_hold_beat: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stb && !i_ack) |=> (i_stb && $stable(i_adr) && $stable(i_cti)))
                else $error("beat changed while waiting for ack");

        a_eob_last: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stb && (i_cti == CTI_EOB)) |-> (i_beat == OFS_W'(LINE_WORDS - 1)))
                else $error("end of burst before the last beat of a line");

endmodule

bind line_burst cache_properties u_props (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_cyc   (o_wb_cyc),
        .i_stb   (o_wb_stb),
        .i_ack   (i_wb_ack),
        .i_adr   (o_wb_adr),
        .i_cti   (o_wb_cti),
        .i_beat  (cnt_q)
);

//--- test/tb_cache.sv
// Cache testbench: clock, LFSR stimulus, Wishbone memory slave,
// byte-level reference model and checks
`timescale 1ns/1ps

module tb_cache;
        import cache_pkg::*;

        localparam int CLK_PERIOD = 40;
        localparam int NUM_OPS    = 400;
        localparam int OP_CYCLES  = 64;     // Writeback plus fill with slowest acks
        localparam int MEM_WORDS  = 4096;   // 16 KB behind the bus
        localparam int TIMEOUT_NS = (2 * NUM_OPS + 24) * OP_CYCLES * CLK_PERIOD;

        logic        i_clk;
        logic        i_reset;
        logic        i_rd;
        logic        i_wr;
        logic [31:0] i_address;
        logic [31:0] i_din;
        logic [3:0]  i_ben;
        logic        i_cache_en;
        logic [31:0] o_dat;
        logic        o_ack;
        logic        o_retry;
        logic        o_wb_cyc;
        logic        o_wb_stb;
        logic        o_wb_we;
        logic [31:0] o_wb_adr;
        logic [31:0] o_wb_dat;
        logic [3:0]  o_wb_sel;
        logic [2:0]  o_wb_cti;
        logic        i_wb_ack;
        logic [31:0] i_wb_dat;

        logic [31:0] mem   [MEM_WORDS];        // Slave memory
        logic [7:0]  model [4 * MEM_WORDS];    // Memory as the CPU sees it
        logic [31:0] stim_lfsr;
        logic [31:0] slave_lfsr;
        int          errors;
        int          checks;
        int          single_beats;
        logic [31:0] single_adr;
        int          line_beats;
        logic [31:0] line_base;

        cache_top u_dut (.*);

        initial
        begin
                i_clk = 1'b0;
                forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end

        // --------------------
        // Helpers
        // --------------------
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        // One LFSR step per bit, separate stream for the slave
        function automatic logic [31:0] rand_bits(input bit for_slave, input int n);
                logic [31:0] v;
                v = '0;
                for (int k = 0; k < n; k++)
                begin
                        if (for_slave)
                        begin
                                slave_lfsr = lfsr_step(slave_lfsr);
                                v = {v[30:0], slave_lfsr[0]};
                        end
                        else
                        begin
                                stim_lfsr = lfsr_step(stim_lfsr);
                                v = {v[30:0], stim_lfsr[0]};
                        end
                end
                return v;
        endfunction

        function automatic logic [31:0] fill_word(input int unsigned w);
                return (w * 32'h9e37_79b1) ^ 32'h5a5a_3c3c;
        endfunction

        function automatic logic [31:0] model_word(input logic [31:0] addr);
                logic [13:0] a;
                a = {addr[13:2], 2'b00};
                return {model[a + 3], model[a + 2], model[a + 1], model[a]};
        endfunction

        task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                                   input string what);
                checks++;
                if (got !== exp)
                begin
                        $display("Error at %0d ns: %s, got %h, expected %h",
                                 $time, what, got, exp);
                        errors++;
                end
        endtask

        // --------------------
        // Wishbone slave
        // --------------------
        task automatic serve_beat();
                logic [31:0] word;
                word = mem[o_wb_adr[13:2]];
                check_value(o_wb_adr & 32'hffff_c000, 32'h0, "bus address inside memory");
                if (o_wb_cti == CTI_CLASSIC)
                begin
                        single_beats++;
                        single_adr = o_wb_adr;
                end
                else
                begin
                        if (line_beats == 0)
                                line_base = o_wb_adr;
                        check_value(line_base & 32'hf, 32'h0, "burst base line aligned");
                        check_value(o_wb_adr, line_base + 4 * line_beats, "burst beat address");
                        check_value(o_wb_cti, (line_beats == 3) ? CTI_EOB : CTI_BURST,
                                    "burst cycle type");
                        line_beats = (line_beats + 1) % 4;
                end
                if (o_wb_we)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                if (o_wb_sel[b])
                                        word[8*b +: 8] = o_wb_dat[8*b +: 8];
                        end
                        mem[o_wb_adr[13:2]] = word;
                end
                i_wb_dat = word;
        endtask

        initial
        begin
                int wait_cnt;
                i_wb_ack   = 1'b0;
                i_wb_dat   = '0;
                wait_cnt   = 0;
                line_beats = 0;
                forever
                begin
                        @(negedge i_clk);
                        i_wb_ack = 1'b0;
                        if (o_wb_cyc && o_wb_stb)
                        begin
                                if (wait_cnt > 0)
                                        wait_cnt--;   // Back-pressure
                                else
                                begin
                                        serve_beat();
                                        i_wb_ack = 1'b1;
                                        wait_cnt = rand_bits(1'b1, 2);
                                end
                        end
                end
        end

        // --------------------
        // CPU driver
        // --------------------
        task automatic run_access(input logic wr, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [3:0] ben,
                                  input logic en);
                logic done;
                done = 1'b0;
                single_beats = 0;
                while (!done)
                begin
                        @(negedge i_clk);
                        i_rd       = !wr;
                        i_wr       = wr;
                        i_address  = addr;
                        i_din      = data;
                        i_ben      = ben;
                        i_cache_en = en;
                        @(posedge i_clk);
                        while (!o_ack)
                                @(posedge i_clk);
                        done = !o_retry;   // Retry means issue it again
                end
                if (wr)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                if (ben[b])
                                        model[{addr[13:2], 2'b00} + b] = data[8*b +: 8];
                        end
                end
                else
                        check_value(o_dat, model_word(addr), $sformatf("read of %h", addr));
                if (en)
                        check_value(single_beats, 0, "cached access made a classic beat");
                else
                begin
                        check_value(single_beats, 1, "uncached access beat count");
                        check_value(single_adr, addr, "uncached beat address");
                end
        endtask

        initial
        begin
                logic        wr;
                logic        en;
                logic [3:0]  ben;
                logic [31:0] addr;
                logic [31:0] data;
                stim_lfsr  = 32'h9fa;
                slave_lfsr = 32'h9fa;
                errors     = 0;
                checks     = 0;
                i_reset    = 1'b1;
                i_rd       = 1'b0;
                i_wr       = 1'b0;
                i_address  = '0;
                i_din      = '0;
                i_ben      = '0;
                i_cache_en = 1'b1;
                for (int w = 0; w < MEM_WORDS; w++)
                begin
                        mem[w] = fill_word(w);
                        for (int b = 0; b < 4; b++)
                                model[4*w + b] = mem[w][8*b +: 8];
                end
                repeat (4) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;

                for (int n = 0; n < NUM_OPS; n++)
                begin
                        en   = (rand_bits(1'b0, 4) >= 3);
                        wr   = rand_bits(1'b0, 1);
                        data = rand_bits(1'b0, 32);
                        ben  = wr ? rand_bits(1'b0, 4) : 4'hf;
                        if (ben == 4'h0)
                                ben = 4'hf;
                        if (en)   // Four tags share four indexes
                                addr = 32'h1000 | (rand_bits(1'b0, 2) << 8) |
                                       (rand_bits(1'b0, 2) << 4) | (rand_bits(1'b0, 2) << 2);
                        else
                                addr = 32'h2000 | (rand_bits(1'b0, 6) << 2);
                        run_access(wr, addr, data, ben, en);
                        if (wr && rand_bits(1'b0, 1))
                                run_access(1'b0, addr, 32'h0, 4'hf, en);
                end

                // Unused tag on every index pushes out the dirty lines
                for (int i = 0; i < 4; i++)
                        run_access(1'b0, 32'h1400 | (i << 4), 32'h0, 4'hf, 1'b1);
                @(negedge i_clk);
                i_rd = 1'b0;
                i_wr = 1'b0;
                for (int w = 0; w < MEM_WORDS; w++)
                        check_value(mem[w], model_word(w << 2), $sformatf("memory at %h", w << 2));

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("SIMULATION PASSED");
                else
                        $display("SIMULATION FAILED");
                $finish;
        end

        // Watchdog
        initial
        begin
                #(TIMEOUT_NS);
                $display("Timeout: the cache did not finish all accesses within %0d ns", TIMEOUT_NS);
                $display("SIMULATION FAILED");
                $finish;
        end

endmodule

//--- tb.f
design/cache_pkg.sv
design/cache_store.sv
design/line_burst.sv
design/cache_ctrl.sv
design/cache_top.sv
test/cache_properties.sv
test/tb_cache.sv
